// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) decode_config.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) decode_stimulus.txt
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== decode_asserts.sv ====
`include "decode_config.svh"

module decode_asserts
    import mips_isa_pkg::*;
    import decode_pkg::*;
(
    input logic     clock,
    input logic     reset,
    input logic     stall,
    input word_t    out_pcs [`ISSUE_WIDTH],
    input command_t command [`ISSUE_WIDTH],
    input logic     sel_imm [`ISSUE_WIDTH]
);

    timeunit 1ns;
    timeprecision 100ps;

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_slot
        // the stage register empties on the edge that samples reset
        pcs_zero_after_reset: assert property (
            @(posedge clock) reset |=> out_pcs[i] == '0
        ) else $error("out_pcs[%0d] is not zero after reset", i);

        pcs_held_in_stall: assert property (
            @(posedge clock) (stall && !reset) |=> $stable(out_pcs[i])
        ) else $error("out_pcs[%0d] changed while the stage was stalled", i);

        store_selects_imm: assert property (
            @(posedge clock) disable iff (reset) command[i] == CMD_STORE |-> sel_imm[i]
        ) else $error("slot %0d decoded a store without the immediate selected", i);
    end

endmodule

// ==== decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// slots per fetch bundle, the stage works with 1 to 8
`define ISSUE_WIDTH 4

// instruction word and program counter width
`define XLEN 32

// register number width, 32 architectural registers
`define REG_ADDR_W 5

`endif

// ==== decode_pkg.sv ====
package decode_pkg;

    typedef logic [2:0] command_t;
    typedef logic [5:0] control_t;
    typedef logic [2:0] imm_kind_t;
    typedef logic [1:0] target_kind_t;
    typedef logic [1:0] dest_kind_t;

    localparam command_t CMD_NONE        = 3'd0;
    localparam command_t CMD_ALU         = 3'd1;
    localparam command_t CMD_JUMP_BRANCH = 3'd2;
    localparam command_t CMD_LOAD        = 3'd3;
    localparam command_t CMD_STORE       = 3'd7;

    // immediate ALU ops reuse the matching R-type funct codes
    localparam control_t CTRL_NONE = 6'b000000;
    localparam control_t CTRL_ADD  = 6'b100000;
    localparam control_t CTRL_AND  = 6'b100100;
    localparam control_t CTRL_OR   = 6'b100101;
    localparam control_t CTRL_XOR  = 6'b100110;
    localparam control_t CTRL_SLT  = 6'b101010;
    localparam control_t CTRL_LUI  = 6'b111111;
    localparam control_t CTRL_BEQ  = 6'd1;
    localparam control_t CTRL_BNE  = 6'd2;
    localparam control_t CTRL_J    = 6'd3;
    localparam control_t CTRL_JAL  = 6'd4;

    localparam imm_kind_t IMM_NONE    = 3'd0;
    localparam imm_kind_t IMM_SHAMT   = 3'd1; // zero-extended shift amount
    localparam imm_kind_t IMM_SEXT16  = 3'd2;
    localparam imm_kind_t IMM_ZEXT16  = 3'd3;
    localparam imm_kind_t IMM_UPPER16 = 3'd4; // immediate in the upper half
    localparam imm_kind_t IMM_LINK    = 3'd5; // return address pc + 4

    localparam target_kind_t TGT_NONE   = 2'd0;
    localparam target_kind_t TGT_NEXT   = 2'd1;
    localparam target_kind_t TGT_BRANCH = 2'd2;
    localparam target_kind_t TGT_JUMP   = 2'd3;

    localparam dest_kind_t DEST_NONE = 2'd0;
    localparam dest_kind_t DEST_RD   = 2'd1;
    localparam dest_kind_t DEST_RT   = 2'd2;

endpackage

// ==== decode_stage.sv ====
`include "decode_config.svh"

module decode_stage
    import mips_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      clear,
    input  logic      stall,
    input  word_t     instructions   [`ISSUE_WIDTH],
    input  word_t     pcs            [`ISSUE_WIDTH],
    output reg_addr_t rd             [`ISSUE_WIDTH],
    output reg_addr_t rs             [`ISSUE_WIDTH],
    output reg_addr_t rt             [`ISSUE_WIDTH],
    output command_t  command        [`ISSUE_WIDTH],
    output control_t  control_signal [`ISSUE_WIDTH],
    output logic      sel_imm        [`ISSUE_WIDTH],
    output word_t     imm            [`ISSUE_WIDTH],
    output word_t     target_pc      [`ISSUE_WIDTH],
    output word_t     out_pcs        [`ISSUE_WIDTH]
);

    word_t slot_words [`ISSUE_WIDTH];
    word_t slot_pcs   [`ISSUE_WIDTH];

    decode_stage_reg stage_reg_i (
        .clock        (clock),
        .reset        (reset),
        .clear        (clear),
        .stall        (stall),
        .instructions (instructions),
        .pcs          (pcs),
        .slot_words   (slot_words),
        .slot_pcs     (slot_pcs)
    );

    // decoded fields are combinational after the stage register
    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_slot
        slot_ctrl_if ctrl ();

        slot_decoder decoder_i (
            .word           (slot_words[i]),
            .ctrl           (ctrl.decoder),
            .command        (command[i]),
            .control_signal (control_signal[i]),
            .sel_imm        (sel_imm[i])
        );

        operand_former former_i (
            .word      (slot_words[i]),
            .pc        (slot_pcs[i]),
            .ctrl      (ctrl.former),
            .rd        (rd[i]),
            .rs        (rs[i]),
            .rt        (rt[i]),
            .imm       (imm[i]),
            .target_pc (target_pc[i])
        );
    end

    assign out_pcs = slot_pcs;

endmodule

// ==== decode_stage_reg.sv ====
`include "decode_config.svh"

module decode_stage_reg
    import mips_isa_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  clear,
    input  logic  stall,
    input  word_t instructions [`ISSUE_WIDTH],
    input  word_t pcs          [`ISSUE_WIDTH],
    output word_t slot_words   [`ISSUE_WIDTH],
    output word_t slot_pcs     [`ISSUE_WIDTH]
);

    always_ff @(posedge clock) begin
        if (reset) begin
            slot_words <= '{default: '0};
            slot_pcs   <= '{default: '0};
        end else if (!stall) begin
            if (clear) begin
                slot_words <= '{default: '0}; // flush, which decodes as a shift by zero
                slot_pcs   <= '{default: '0};
            end else begin
                slot_words <= instructions;
                slot_pcs   <= pcs;
            end
        end
        // a stalled stage keeps its bundle and ignores clear
    end

endmodule

// ==== decode_stimulus.txt ====
// count, then per vector: stall clear word0-3 pc0-3, per slot: rd rs rt command control
// sel_imm imm target_pc, then out_pcs0-3 (all hex)
0b
1 0 2022fffd 24838001 29058000 2d268000 1000 1004 1008 100c 0 0 0 1 0 1 0 4 0 0 0 1 0 1 0 4 0 0 0 1 0 1 0 4 0 0 0 1 0 1 0 4 0 0 0 0
0 0 2022fffd 24838001 29058000 2d268000 1000 1004 1008 100c 2 1 0 1 20 1 fffffffd 0 3 4 0 1 20 1 8001 0 5 8 0 1 2a 1 ffff8000 0 6 9 0 1 2a 1 8000 0 1000 1004 1008 100c
0 0 302af0f0 344b1234 386cabcd 3c0d8765 1010 1014 1018 101c a 1 0 1 24 1 f0f0 0 b 2 0 1 25 1 1234 0 c 3 0 1 26 1 abcd 0 d 0 0 1 3f 1 87650000 0 1010 1014 1018 101c
0 0 8fb10008 8c82fffc afa50010 ac268000 1020 1024 1028 102c 11 1d 0 3 0 1 8 0 2 4 0 3 0 1 fffffffc 0 5 1d 0 7 0 1 10 0 6 1 0 7 0 1 ffff8000 0 1020 1024 1028 102c
0 0 10220003 1465fffe 1000ffff 15090100 2000 2004 2008 200c 0 1 2 2 1 0 0 2010 0 3 5 2 2 0 0 2000 0 0 0 2 1 0 0 2008 0 8 9 2 2 0 0 2410 2000 2004 2008 200c
0 0 08100040 0fffffff 0c000010 08000000 90000100 90000104 90000108 9000010c 0 0 0 2 3 0 0 90400100 0 0 0 2 4 1 90000108 9ffffffc 0 0 0 2 4 1 9000010c 90000040 0 0 0 2 3 0 0 90000000 90000100 90000104 90000108 9000010c
0 0 000219c0 00a62020 03e00008 fc221234 3000 3004 3008 300c 3 0 2 1 0 1 7 3004 4 5 6 1 20 0 0 3008 0 1f 0 2 8 0 0 300c 0 0 0 0 0 0 0 0 3000 3004 3008 300c
1 0 302af0f0 344b1234 386cabcd 3c0d8765 5000 5004 5008 500c 3 0 2 1 0 1 7 3004 4 5 6 1 20 0 0 3008 0 1f 0 2 8 0 0 300c 0 0 0 0 0 0 0 0 3000 3004 3008 300c
1 1 302af0f0 344b1234 386cabcd 3c0d8765 5000 5004 5008 500c 3 0 2 1 0 1 7 3004 4 5 6 1 20 0 0 3008 0 1f 0 2 8 0 0 300c 0 0 0 0 0 0 0 0 3000 3004 3008 300c
0 1 8fb10008 8c82fffc afa50010 ac268000 6000 6004 6008 600c 0 0 0 1 0 1 0 4 0 0 0 1 0 1 0 4 0 0 0 1 0 1 0 4 0 0 0 1 0 1 0 4 0 0 0 0
0 0 2022fffd 24838001 29058000 2d268000 1000 1004 1008 100c 2 1 0 1 20 1 fffffffd 0 3 4 0 1 20 1 8001 0 5 8 0 1 2a 1 ffff8000 0 6 9 0 1 2a 1 8000 0 1000 1004 1008 100c

// ==== mips_isa_pkg.sv ====
`include "decode_config.svh"

package mips_isa_pkg;

    localparam int IMM_W       = 16;                // I-type immediate field
    localparam int INDEX_W     = 26;                // J-type index field
    localparam int PC_REGION_W = `XLEN - INDEX_W - 2; // PC bits kept by j and jal

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [5:0]             opcode_t;
    typedef logic [5:0]             funct_t;
    typedef logic [4:0]             shamt_t;
    typedef logic [IMM_W-1:0]       imm16_t;
    typedef logic [INDEX_W-1:0]     index_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    shamt;
        funct_t    funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        imm16_t    imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_t opcode;
        index_t  index;
    } j_fmt_t;

    localparam opcode_t OPC_RTYPE = 6'b000000;
    localparam opcode_t OPC_J     = 6'b000010;
    localparam opcode_t OPC_JAL   = 6'b000011;
    localparam opcode_t OPC_BEQ   = 6'b000100;
    localparam opcode_t OPC_BNE   = 6'b000101;
    localparam opcode_t OPC_ADDI  = 6'b001000;
    localparam opcode_t OPC_ADDIU = 6'b001001;
    localparam opcode_t OPC_SLTI  = 6'b001010;
    localparam opcode_t OPC_SLTIU = 6'b001011;
    localparam opcode_t OPC_ANDI  = 6'b001100;
    localparam opcode_t OPC_ORI   = 6'b001101;
    localparam opcode_t OPC_XORI  = 6'b001110;
    localparam opcode_t OPC_LUI   = 6'b001111;
    localparam opcode_t OPC_LW    = 6'b100011;
    localparam opcode_t OPC_SW    = 6'b101011;

    // funct groups, matched on the upper bits only
    localparam logic [3:0] FUNCT_SHIFT_GRP = 4'b0000; // sll .. srav, take shamt
    localparam logic [2:0] FUNCT_JUMP_GRP  = 3'b001;  // jr and jalr

endpackage

// ==== operand_former.sv ====
`include "decode_config.svh"

module operand_former
    import mips_isa_pkg::*;
    import decode_pkg::*;
(
    input  word_t               word,
    input  word_t               pc,
    slot_ctrl_if.former         ctrl,
    output reg_addr_t           rd,
    output reg_addr_t           rs,
    output reg_addr_t           rt,
    output word_t               imm,
    output word_t               target_pc
);

    r_fmt_t r_fields;
    i_fmt_t i_fields;
    j_fmt_t j_fields;
    word_t  pc_plus4;
    word_t  branch_offset;

    assign r_fields = r_fmt_t'(word);
    assign i_fields = i_fmt_t'(word);
    assign j_fields = j_fmt_t'(word);

    assign pc_plus4      = pc + word_t'(4);
    // word offset, sign-extended and scaled to bytes
    assign branch_offset = {{(`XLEN-IMM_W-2){i_fields.imm[IMM_W-1]}}, i_fields.imm, 2'b00};

    assign rs = ctrl.rs_used ? r_fields.rs : '0;
    assign rt = ctrl.rt_used ? r_fields.rt : '0;

    always_comb begin
        case (ctrl.dest_kind)
            DEST_RD: rd = r_fields.rd;
            DEST_RT: rd = r_fields.rt;
            default: rd = '0;
        endcase
    end

    always_comb begin
        case (ctrl.imm_kind)
            IMM_SHAMT:   imm = word_t'(r_fields.shamt);
            IMM_SEXT16:  imm = {{(`XLEN-IMM_W){i_fields.imm[IMM_W-1]}}, i_fields.imm};
            IMM_ZEXT16:  imm = word_t'(i_fields.imm);
            IMM_UPPER16: imm = {i_fields.imm, {(`XLEN-IMM_W){1'b0}}};
            IMM_LINK:    imm = pc_plus4;
            default:     imm = '0;
        endcase
    end

    always_comb begin
        case (ctrl.target_kind)
            TGT_NEXT:   target_pc = pc_plus4;
            TGT_BRANCH: target_pc = pc_plus4 + branch_offset;
            TGT_JUMP:   target_pc = {pc[`XLEN-1 -: PC_REGION_W], j_fields.index, 2'b00};
            default:    target_pc = '0;
        endcase
    end

endmodule

// ==== slot_ctrl_if.sv ====
interface slot_ctrl_if
    import decode_pkg::*;
();

    imm_kind_t    imm_kind;    // how the immediate is built
    target_kind_t target_kind; // how the target pc is built
    dest_kind_t   dest_kind;   // which field names the destination
    logic         rs_used;
    logic         rt_used;

    modport decoder (
        output imm_kind, target_kind, dest_kind, rs_used, rt_used
    );

    modport former (
        input imm_kind, target_kind, dest_kind, rs_used, rt_used
    );

endinterface

// ==== slot_decoder.sv ====
module slot_decoder
    import mips_isa_pkg::*;
    import decode_pkg::*;
(
    input  word_t               word,
    slot_ctrl_if.decoder        ctrl,
    output command_t            command,
    output control_t            control_signal,
    output logic                sel_imm
);

    r_fmt_t fields;

    assign fields = r_fmt_t'(word);

    always_comb begin
        command          = CMD_NONE; // unknown opcodes fall through as all zeros
        control_signal   = CTRL_NONE;
        sel_imm          = 1'b0;
        ctrl.imm_kind    = IMM_NONE;
        ctrl.target_kind = TGT_NONE;
        ctrl.dest_kind   = DEST_NONE;
        ctrl.rs_used     = 1'b0;
        ctrl.rt_used     = 1'b0;

        case (fields.opcode)
            OPC_RTYPE: begin
                control_signal   = control_t'(fields.funct);
                sel_imm          = (fields.funct[5:2] == FUNCT_SHIFT_GRP);
                command          = (fields.funct[5:3] == FUNCT_JUMP_GRP) ? CMD_JUMP_BRANCH
                                                                         : CMD_ALU;
                ctrl.imm_kind    = IMM_SHAMT;
                ctrl.target_kind = TGT_NEXT;
                ctrl.dest_kind   = DEST_RD;
                ctrl.rs_used     = 1'b1;
                ctrl.rt_used     = 1'b1;
            end
            OPC_ADDI, OPC_ADDIU, OPC_ANDI, OPC_ORI,
            OPC_XORI, OPC_LUI, OPC_SLTI, OPC_SLTIU: begin
                command        = CMD_ALU;
                sel_imm        = 1'b1;
                ctrl.dest_kind = DEST_RT; // result goes to the rt register
                ctrl.rs_used   = 1'b1;
                case (fields.opcode)
                    OPC_ADDI, OPC_ADDIU: control_signal = CTRL_ADD;
                    OPC_ANDI:            control_signal = CTRL_AND;
                    OPC_ORI:             control_signal = CTRL_OR;
                    OPC_XORI:            control_signal = CTRL_XOR;
                    OPC_LUI:             control_signal = CTRL_LUI;
                    default:             control_signal = CTRL_SLT; // sltiu shares slt
                endcase
                if (fields.opcode == OPC_ADDI || fields.opcode == OPC_SLTI) begin
                    ctrl.imm_kind = IMM_SEXT16;
                end else if (fields.opcode == OPC_LUI) begin
                    ctrl.imm_kind = IMM_UPPER16;
                end else begin
                    ctrl.imm_kind = IMM_ZEXT16;
                end
            end
            OPC_LW, OPC_SW: begin
                command        = (fields.opcode == OPC_SW) ? CMD_STORE : CMD_LOAD;
                sel_imm        = 1'b1;
                ctrl.imm_kind  = IMM_SEXT16; // address offset
                ctrl.dest_kind = DEST_RT;
                ctrl.rs_used   = 1'b1;
            end
            OPC_BEQ, OPC_BNE: begin
                command          = CMD_JUMP_BRANCH;
                control_signal   = (fields.opcode == OPC_BEQ) ? CTRL_BEQ : CTRL_BNE;
                ctrl.target_kind = TGT_BRANCH;
                ctrl.rs_used     = 1'b1;
                ctrl.rt_used     = 1'b1;
            end
            OPC_J, OPC_JAL: begin
                command          = CMD_JUMP_BRANCH;
                control_signal   = (fields.opcode == OPC_JAL) ? CTRL_JAL : CTRL_J;
                sel_imm          = (fields.opcode == OPC_JAL); // jal writes the link value
                ctrl.imm_kind    = (fields.opcode == OPC_JAL) ? IMM_LINK : IMM_NONE;
                ctrl.target_kind = TGT_JUMP;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== tb_decode_stage.sv ====
`include "decode_config.svh"

module tb_decode_stage
    import mips_isa_pkg::*;
    import decode_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SLOTS       = `ISSUE_WIDTH;
    localparam int SLOT_FIELDS = 8;                          // rd rs rt cmd ctrl sel imm target
    localparam int VEC_FIELDS  = 2 + 3 * SLOTS + SLOT_FIELDS * SLOTS;
    localparam int MAX_VECTORS = 32;

    logic      clock;
    logic      reset;
    logic      clear;
    logic      stall;
    word_t     instructions   [SLOTS];
    word_t     pcs            [SLOTS];
    reg_addr_t rd             [SLOTS];
    reg_addr_t rs             [SLOTS];
    reg_addr_t rt             [SLOTS];
    command_t  command        [SLOTS];
    control_t  control_signal [SLOTS];
    logic      sel_imm        [SLOTS];
    word_t     imm            [SLOTS];
    word_t     target_pc      [SLOTS];
    word_t     out_pcs        [SLOTS];
    word_t     vec_mem        [1 + MAX_VECTORS * VEC_FIELDS]; // word 0 is the vector count
    int        vector_count;
    int        current_vector;
    int        cycle_limit = 0;                                // zero until the file is loaded
    int        cycle_count = 0;

    decode_stage decode_stage_i (
        .clock          (clock),
        .reset          (reset),
        .clear          (clear),
        .stall          (stall),
        .instructions   (instructions),
        .pcs            (pcs),
        .rd             (rd),
        .rs             (rs),
        .rt             (rt),
        .command        (command),
        .control_signal (control_signal),
        .sel_imm        (sel_imm),
        .imm            (imm),
        .target_pc      (target_pc),
        .out_pcs        (out_pcs)
    );

    bind decode_stage decode_asserts asserts_i (
        .clock   (clock),
        .reset   (reset),
        .stall   (stall),
        .out_pcs (out_pcs),
        .command (command),
        .sel_imm (sel_imm)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the vectors did not finish", cycle_count);
            $display("** FAIL **");
            $fatal(1, "simulation stopped");
        end
    end

    task automatic check_equal(input string name, input int slot, input word_t expected,
                               input word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s[%0d] in vector %0d: expected %h, got %h",
                     name, slot, current_vector, expected, actual);
            $display("** FAIL **");
            $fatal(1, "simulation stopped at the first mismatch");
        end
    endtask

    task automatic apply_vector(input int k);
        int base;
        base  = 1 + k * VEC_FIELDS;
        stall = vec_mem[base][0];
        clear = vec_mem[base + 1][0];
        for (int s = 0; s < SLOTS; s++) begin
            instructions[s] = vec_mem[base + 2 + s];
            pcs[s]          = vec_mem[base + 2 + SLOTS + s];
        end
    endtask

    task automatic check_vector(input int k);
        int e;
        int o;
        current_vector = k;
        o = 1 + k * VEC_FIELDS + 2 + 2 * SLOTS + SLOT_FIELDS * SLOTS; // out_pcs columns
        for (int s = 0; s < SLOTS; s++) begin
            e = 1 + k * VEC_FIELDS + 2 + 2 * SLOTS + s * SLOT_FIELDS;
            check_equal("rd", s, vec_mem[e], word_t'(rd[s]));
            check_equal("rs", s, vec_mem[e + 1], word_t'(rs[s]));
            check_equal("rt", s, vec_mem[e + 2], word_t'(rt[s]));
            check_equal("command", s, vec_mem[e + 3], word_t'(command[s]));
            check_equal("control_signal", s, vec_mem[e + 4], word_t'(control_signal[s]));
            check_equal("sel_imm", s, vec_mem[e + 5], word_t'(sel_imm[s]));
            check_equal("imm", s, vec_mem[e + 6], imm[s]);
            check_equal("target_pc", s, vec_mem[e + 7], target_pc[s]);
            check_equal("out_pcs", s, vec_mem[o + s], out_pcs[s]);
        end
    endtask

    initial begin
        reset        = 1'b1;
        clear        = 1'b0;
        stall        = 1'b0;
        instructions = '{default: '0};
        pcs          = '{default: '0};
        vec_mem      = '{default: '0};
        $readmemh("decode_stimulus.txt", vec_mem);
        vector_count = int'(vec_mem[0]);
        if (vector_count < 1 || vector_count > MAX_VECTORS) begin
            $display("the stimulus file gives no usable vector count");
            $display("** FAIL **");
            $fatal(1, "simulation stopped");
        end
        cycle_limit = 2 * vector_count + 10;
        repeat (3) @(posedge clock);
        #5;
        reset = 1'b0;
        // the first vector stalls, so its check sees the register as reset left it
        apply_vector(0);
        for (int k = 0; k < vector_count; k++) begin
            @(posedge clock);
            #5;
            if (k + 1 < vector_count) begin
                apply_vector(k + 1);
            end
            #90;
            check_vector(k);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
mips_isa_pkg.sv
decode_pkg.sv
slot_ctrl_if.sv
decode_stage_reg.sv
slot_decoder.sv
operand_former.sv
decode_stage.sv
decode_asserts.sv
tb_decode_stage.sv
